// File: flist.f
verilog/spi_reg_pkg.sv
verilog/spi_frame_decode.sv
verilog/fix_reg_list.sv
verilog/ctrl_reg_list.sv
verilog/spi_read_shift.sv
verilog/spi_reg_top.sv
test/spi_reg_tb.sv

// File: Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert
TOP     = spi_reg_tb
FLIST   = flist.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: test/spi_reg_tb.sv
`default_nettype none
`timescale 1ns/1ps

module spi_reg_tb;
	import spi_reg_pkg::*;

	// identification values given to the DUT
	localparam reg_data_t VENDOR_ID = 16'h4448;
	localparam reg_data_t PRODUCT_ID = 16'h1234;
	localparam reg_data_t FPGA_VERSION_H = 16'h0101;
	localparam reg_data_t FPGA_VERSION_L = 16'h010c;
	// sample cycles per sclk half period
	localparam int HALF_CYCLES = 4;
	localparam int MISO_LIMIT = 20;
	localparam int DRAIN_LIMIT = 50;

	logic clk_spi_sample;
	logic rst_n;
	logic sclk;
	logic cs_n;
	logic mosi;
	logic miso;
	ctrl_regs_t ctrl_regs;

	reg_data_t shadow [4];
	spi_addr_t addr_q [$];
	reg_data_t got_q [$];
	reg_data_t exp_q [$];
	logic [31:0] rng_state;
	int checks;
	int errors;
	int test_errors;
	int test_num;

	spi_reg_top #(
		.VENDOR_ID(VENDOR_ID),
		.PRODUCT_ID(PRODUCT_ID),
		.FPGA_VERSION_H(FPGA_VERSION_H),
		.FPGA_VERSION_L(FPGA_VERSION_L),
		.SYNC_STAGES(2)
	) spi_reg_top_i (
		.clk_spi_sample(clk_spi_sample),
		.rst_n(rst_n),
		.sclk(sclk),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.ctrl_regs(ctrl_regs)
	);

	// 50 MHz sample clock
	initial begin
		clk_spi_sample = 1'b0;
		forever #10 clk_spi_sample = ~clk_spi_sample;
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// only address bits 8 to 0 count
	function automatic reg_data_t ref_read(input spi_addr_t addr);
		case (addr[8:0])
			9'h000: return VENDOR_ID;
			9'h001: return PRODUCT_ID;
			9'h002: return FPGA_VERSION_H;
			9'h003: return FPGA_VERSION_L;
			9'h010: return shadow[0];
			9'h011: return shadow[1];
			9'h012: return shadow[2];
			9'h013: return shadow[3];
			default: return 16'h0000;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// read words checked against the model in arrival order
	always @(posedge clk_spi_sample) begin
		while (got_q.size() > 0) begin
			check_value($sformatf("miso word of addr %h", addr_q.pop_front()),
				got_q.pop_front(), exp_q.pop_front());
		end
	end

	// ------------------------------
	// SPI master
	// ------------------------------
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_spi_sample);
	endtask

	// mode 0, msb first, nbits below 40 cuts the frame short
	task automatic spi_frame(input opcode_t opc, input spi_addr_t addr, input reg_data_t wdata,
			input int nbits, output reg_data_t rdata);
		logic [39:0] frame;
		frame = {opc, addr, wdata};
		rdata = '0;
		@(negedge clk_spi_sample);
		sclk = 1'b0;
		cs_n = 1'b0;
		wait_cycles(HALF_CYCLES);
		for (int i = 0; i < nbits; i++) begin
			mosi = frame[39 - i];
			wait_cycles(HALF_CYCLES);
			// miso taken as sclk rises, data phase only
			if (i >= 24) begin
				rdata[39 - i] = miso;
			end
			sclk = 1'b1;
			wait_cycles(HALF_CYCLES);
			sclk = 1'b0;
		end
		wait_cycles(HALF_CYCLES);
		cs_n = 1'b1;
		mosi = 1'b0;
		wait_cycles(2 * HALF_CYCLES);
	endtask

	task automatic wait_miso_low();
		int n;
		n = 0;
		while (miso !== 1'b0 && n < MISO_LIMIT) begin
			@(negedge clk_spi_sample);
			n++;
		end
		if (miso !== 1'b0) begin
			errors++;
			$display("miso still high %0d cycles after cs_n rose", MISO_LIMIT);
		end
	endtask

	task automatic check_ctrl();
		check_value("ctrl_regs.ctrl0", ctrl_regs.ctrl0, shadow[0]);
		check_value("ctrl_regs.ctrl1", ctrl_regs.ctrl1, shadow[1]);
		check_value("ctrl_regs.ctrl2", ctrl_regs.ctrl2, shadow[2]);
		check_value("ctrl_regs.ctrl3", ctrl_regs.ctrl3, shadow[3]);
	endtask

	task automatic write_reg(input spi_addr_t addr, input reg_data_t data);
		reg_data_t rd;
		spi_frame(OPC_WRITE, addr, data, 40, rd);
		// shadow follows control addresses only
		if (addr[8:0] >= 9'h010 && addr[8:0] <= 9'h013) begin
			shadow[addr[1:0]] = data;
		end
		check_ctrl();
		wait_miso_low();
	endtask

	task automatic read_reg(input spi_addr_t addr);
		reg_data_t rd;
		spi_frame(OPC_READ, addr, 16'h0000, 40, rd);
		addr_q.push_back(addr);
		exp_q.push_back(ref_read(addr));
		got_q.push_back(rd);
		check_ctrl();
		wait_miso_low();
	endtask

	// mix of id, control and arbitrary addresses, upper bits random
	task automatic random_frame();
		logic [31:0] r1;
		logic [31:0] r2;
		spi_addr_t addr;
		r1 = next_random();
		r2 = next_random();
		case (r1[1:0])
			2'd0: addr[8:0] = {7'h00, r1[3:2]};
			2'd1: addr[8:0] = {7'h04, r1[3:2]};
			default: addr[8:0] = r1[12:4];
		endcase
		addr[15:9] = r1[19:13];
		if (r1[20]) begin
			write_reg(addr, r2[15:0]);
		end else begin
			read_reg(addr);
		end
	endtask

	task automatic finish_test(input string name);
		int n;
		n = 0;
		while (got_q.size() > 0 && n < DRAIN_LIMIT) begin
			@(negedge clk_spi_sample);
			n++;
		end
		if (got_q.size() > 0) begin
			errors++;
			$display("read words were never compared within %0d cycles", DRAIN_LIMIT);
		end
		$display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
		test_errors = errors;
		test_num++;
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		reg_data_t rd;
		rst_n = 1'b0;
		sclk = 1'b0;
		cs_n = 1'b1;
		mosi = 1'b0;
		rng_state = 32'ha08c_e819;
		checks = 0;
		errors = 0;
		test_errors = 0;
		test_num = 1;
		for (int i = 0; i < 4; i++) begin
			shadow[i] = '0;
		end
		repeat (2) @(negedge clk_spi_sample);
		rst_n = 1'b1;
		wait_cycles(4);
		check_ctrl();
		check_value("miso", {15'd0, miso}, 16'h0000);

		// id registers, then aliases through the upper bits
		for (int a = 0; a < 4; a++) begin
			read_reg(16'(a));
		end
		read_reg(16'h0200);
		read_reg(16'hfe01);
		read_reg(16'h8402);
		read_reg(16'h1203);
		finish_test("identification reads");

		write_reg(16'h0010, 16'hbeef);
		write_reg(16'h0011, 16'h0123);
		write_reg(16'h0012, 16'ha5a5);
		write_reg(16'h0013, 16'h7e81);
		for (int a = 16; a < 20; a++) begin
			read_reg(16'(a));
		end
		finish_test("control writes");

		read_reg(16'h0004);
		read_reg(16'h000f);
		read_reg(16'h0014);
		read_reg(16'h01ff);
		read_reg(16'h0100);
		// writes that must go nowhere
		write_reg(16'h0000, 16'hffff);
		write_reg(16'h0003, 16'h5555);
		write_reg(16'h0020, 16'h1357);
		write_reg(16'h0114, 16'h2468);
		for (int a = 0; a < 4; a++) begin
			read_reg(16'(a));
			read_reg(16'(a + 16));
		end
		read_reg(16'h0020);
		finish_test("unmapped access");

		// unknown opcode, then writes cut off by cs_n
		spi_frame(8'h5a, 16'h0010, 16'h1111, 40, rd);
		check_ctrl();
		spi_frame(OPC_WRITE, 16'h0011, 16'h2222, 36, rd);
		check_ctrl();
		spi_frame(OPC_WRITE, 16'h0012, 16'h3333, 24, rd);
		check_ctrl();
		read_reg(16'h0011);
		read_reg(16'h0001);
		finish_test("aborted frames");

		for (int n = 0; n < 200; n++) begin
			random_frame();
		end
		finish_test("random frames");

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/spi_reg_top.sv
`default_nettype none
`timescale 1ns/1ps

module spi_reg_top #(
	parameter spi_reg_pkg::reg_data_t VENDOR_ID = 16'h4448,
	parameter spi_reg_pkg::reg_data_t PRODUCT_ID = 16'h1234,
	parameter spi_reg_pkg::reg_data_t FPGA_VERSION_H = 16'h0101,
	parameter spi_reg_pkg::reg_data_t FPGA_VERSION_L = 16'h010c,
	parameter int SYNC_STAGES = 2
) (
	input wire clk_spi_sample,
	input wire rst_n,
	input wire sclk,
	input wire cs_n,
	input wire mosi,
	output logic miso,
	output spi_reg_pkg::ctrl_regs_t ctrl_regs
);
	import spi_reg_pkg::*;

	reg_cmd_t cmd;
	reg_rd_t fix_rd;
	reg_rd_t ctrl_rd;

	// ------------------------------
	// decode
	// ------------------------------
	spi_frame_decode #(
		.SYNC_STAGES(SYNC_STAGES)
	) spi_frame_decode_i (
		.clk_spi_sample(clk_spi_sample),
		.rst_n(rst_n),
		.sclk(sclk),
		.cs_n(cs_n),
		.mosi(mosi),
		.cmd(cmd)
	);

	// ------------------------------
	// execute
	// ------------------------------
	// identification list
	fix_reg_list #(
		.VENDOR_ID(VENDOR_ID),
		.PRODUCT_ID(PRODUCT_ID),
		.FPGA_VERSION_H(FPGA_VERSION_H),
		.FPGA_VERSION_L(FPGA_VERSION_L)
	) fix_reg_list_i (
		.clk_spi_sample(clk_spi_sample),
		.rst_n(rst_n),
		.cmd(cmd),
		.fix_rd(fix_rd)
	);

	// control list, also feeds the chip
	ctrl_reg_list ctrl_reg_list_i (
		.clk_spi_sample(clk_spi_sample),
		.rst_n(rst_n),
		.cmd(cmd),
		.ctrl_rd(ctrl_rd),
		.ctrl_regs(ctrl_regs)
	);

	// ------------------------------
	// result
	// ------------------------------
	spi_read_shift spi_read_shift_i (
		.clk_spi_sample(clk_spi_sample),
		.rst_n(rst_n),
		.sclk(sclk),
		.cs_n(cs_n),
		.fix_rd(fix_rd),
		.ctrl_rd(ctrl_rd),
		.miso(miso)
	);

endmodule

`default_nettype wire

// File: verilog/spi_read_shift.sv
`default_nettype none
`timescale 1ns/1ps

module spi_read_shift (
	input wire clk_spi_sample,
	input wire rst_n,
	input wire sclk,
	input wire cs_n,
	input wire spi_reg_pkg::reg_rd_t fix_rd,
	input wire spi_reg_pkg::reg_rd_t ctrl_rd,
	output logic miso
);
	import spi_reg_pkg::*;

	localparam logic [4:0] WORD_BITS = 5'(SHORT_REG_WD);

	logic [1:0] sclk_sync;
	logic [1:0] cs_sync;
	logic sclk_d;
	logic sclk_fall;
	logic cs_s;
	logic load;
	reg_data_t load_word;
	reg_data_t shift_q;
	logic active;
	logic [4:0] bit_cnt;

	// ------------------------------
	// local sclk and cs_n sync
	// ------------------------------
	always_ff @(posedge clk_spi_sample) begin
		if (!rst_n) begin
			sclk_sync <= 2'b00;
			cs_sync <= 2'b11;
			sclk_d <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[0], sclk};
			cs_sync <= {cs_sync[0], cs_n};
			sclk_d <= sclk_sync[1];
		end
	end

	assign cs_s = cs_sync[1];
	// mode 0 so miso changes on falling sclk
	assign sclk_fall = sclk_d & ~sclk_sync[1];

	// merged reply, zero when no list answers
	assign load = fix_rd.sel | ctrl_rd.sel;
	assign load_word = ({SHORT_REG_WD{fix_rd.sel}} & fix_rd.data) |
		({SHORT_REG_WD{ctrl_rd.sel}} & ctrl_rd.data);

	// ------------------------------
	// output shifter
	// ------------------------------
	always_ff @(posedge clk_spi_sample) begin
		if (!rst_n || cs_s) begin
			active <= 1'b0;
			bit_cnt <= '0;
			miso <= 1'b0;
		end else if (load) begin
			// first bit goes out on the next falling edge
			active <= 1'b1;
			bit_cnt <= '0;
			miso <= 1'b0;
		end else if (active && sclk_fall) begin
			if (bit_cnt == WORD_BITS) begin
				// word done, back to low
				active <= 1'b0;
				miso <= 1'b0;
			end else begin
				miso <= shift_q[SHORT_REG_WD-1];
				bit_cnt <= bit_cnt + 5'd1;
			end
		end
	end

	// msb first
	always_ff @(posedge clk_spi_sample) begin
		if (load) begin
			shift_q <= load_word;
		end else if (active && sclk_fall) begin
			shift_q <= {shift_q[SHORT_REG_WD-2:0], 1'b0};
		end
	end

	// address ranges of the two lists never overlap
	a_one_sel: assert property (@(posedge clk_spi_sample) disable iff (!rst_n)
		!(fix_rd.sel && ctrl_rd.sel));

endmodule

`default_nettype wire

// File: verilog/ctrl_reg_list.sv
`default_nettype none
`timescale 1ns/1ps

module ctrl_reg_list (
	input wire clk_spi_sample,
	input wire rst_n,
	input wire spi_reg_pkg::reg_cmd_t cmd,
	output spi_reg_pkg::reg_rd_t ctrl_rd,
	output spi_reg_pkg::ctrl_regs_t ctrl_regs
);
	import spi_reg_pkg::*;

	reg_idx_t idx;
	logic in_range;
	reg_data_t rd_word;

	assign idx = cmd.addr[DEC_ADDR_WD-1:0];
	// block of four, compare above the register index
	assign in_range = (idx[DEC_ADDR_WD-1:2] == CTRL_BASE[DEC_ADDR_WD-1:2]);

	// ------------------------------
	// register writes
	// ------------------------------
	always_ff @(posedge clk_spi_sample) begin
		if (!rst_n) begin
			ctrl_regs <= '0;
		end else if (cmd.wr_en && in_range) begin
			case (idx[1:0])
				2'd0: ctrl_regs.ctrl0 <= cmd.wdata;
				2'd1: ctrl_regs.ctrl1 <= cmd.wdata;
				2'd2: ctrl_regs.ctrl2 <= cmd.wdata;
				default: ctrl_regs.ctrl3 <= cmd.wdata;
			endcase
		end
	end

	// ------------------------------
	// read-back
	// ------------------------------
	// word picked by the low address bits
	always_comb begin
		case (idx[1:0])
			2'd0: rd_word = ctrl_regs.ctrl0;
			2'd1: rd_word = ctrl_regs.ctrl1;
			2'd2: rd_word = ctrl_regs.ctrl2;
			default: rd_word = ctrl_regs.ctrl3;
		endcase
	end

	always_ff @(posedge clk_spi_sample) begin
		if (!rst_n) begin
			ctrl_rd <= '0;
		end else if (cmd.rd_en && in_range) begin
			ctrl_rd <= '{sel: 1'b1, data: rd_word};
		end else begin
			// no reply outside our range
			ctrl_rd <= '0;
		end
	end

	// register contents move only on a write command
	a_wr_only: assert property (@(posedge clk_spi_sample) disable iff (!rst_n)
		!$stable(ctrl_regs) |-> $past(cmd.wr_en));

endmodule

`default_nettype wire

// File: verilog/fix_reg_list.sv
`default_nettype none
`timescale 1ns/1ps

module fix_reg_list #(
	parameter spi_reg_pkg::reg_data_t VENDOR_ID = 16'h4448,
	parameter spi_reg_pkg::reg_data_t PRODUCT_ID = 16'h1234,
	parameter spi_reg_pkg::reg_data_t FPGA_VERSION_H = 16'h0101,
	parameter spi_reg_pkg::reg_data_t FPGA_VERSION_L = 16'h010c
) (
	input wire clk_spi_sample,
	input wire rst_n,
	input wire spi_reg_pkg::reg_cmd_t cmd,
	output spi_reg_pkg::reg_rd_t fix_rd
);
	import spi_reg_pkg::*;

	reg_idx_t idx;

	// upper address bits alias onto the same registers
	assign idx = cmd.addr[DEC_ADDR_WD-1:0];

	// ------------------------------
	// identification readout
	// ------------------------------
	always_ff @(posedge clk_spi_sample) begin
		if (!rst_n) begin
			fix_rd <= '0;
		end else if (cmd.rd_en) begin
			case (idx)
				// vendor and product
				9'h000: fix_rd <= '{sel: 1'b1, data: VENDOR_ID};
				9'h001: fix_rd <= '{sel: 1'b1, data: PRODUCT_ID};
				// firmware version
				9'h002: fix_rd <= '{sel: 1'b1, data: FPGA_VERSION_H};
				9'h003: fix_rd <= '{sel: 1'b1, data: FPGA_VERSION_L};
				// not ours
				default: fix_rd <= '0;
			endcase
		end else begin
			// sel lasts one cycle only
			fix_rd <= '0;
		end
	end

	// a reply only ever follows a read pulse
	a_sel_after_rd: assert property (@(posedge clk_spi_sample) disable iff (!rst_n)
		fix_rd.sel |-> $past(cmd.rd_en));

endmodule

`default_nettype wire

// File: verilog/spi_frame_decode.sv
`default_nettype none
`timescale 1ns/1ps

module spi_frame_decode #(
	parameter int SYNC_STAGES = 2
) (
	input wire clk_spi_sample,
	input wire rst_n,
	input wire sclk,
	input wire cs_n,
	input wire mosi,
	output spi_reg_pkg::reg_cmd_t cmd
);
	import spi_reg_pkg::*;

	// pin order in the synchronizer is sclk, cs_n, mosi
	localparam logic [2:0] PIN_IDLE = 3'b010;
	localparam logic [3:0] OPC_LAST = 4'(OPCODE_WD - 1);
	localparam logic [3:0] WORD_LAST = 4'(SHORT_REG_WD - 1);

	logic [2:0] pin_sync [SYNC_STAGES];
	logic sclk_s;
	logic cs_s;
	logic mosi_s;
	logic sclk_d;
	logic cs_d;
	logic sclk_rise;
	logic cs_fall;
	frame_state_t state;
	logic [3:0] bit_cnt;
	reg_data_t shift_q;
	reg_data_t field_word;
	opcode_t opcode_q;
	logic rd_pulse;
	logic wr_pulse;
	spi_addr_t addr_q;
	reg_data_t wdata_q;

	// ------------------------------
	// pin synchronizer and edges
	// ------------------------------
	always_ff @(posedge clk_spi_sample) begin
		if (!rst_n) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				pin_sync[i] <= PIN_IDLE;
			end
			sclk_d <= 1'b0;
			cs_d <= 1'b1;
		end else begin
			pin_sync[0] <= {sclk, cs_n, mosi};
			for (int i = 1; i < SYNC_STAGES; i++) begin
				pin_sync[i] <= pin_sync[i-1];
			end
			sclk_d <= sclk_s;
			cs_d <= cs_s;
		end
	end

	assign {sclk_s, cs_s, mosi_s} = pin_sync[SYNC_STAGES-1];
	// mode 0 so mosi is sampled on rising sclk
	assign sclk_rise = sclk_s & ~sclk_d;
	assign cs_fall = cs_d & ~cs_s;
	// word including the bit arriving on this edge
	assign field_word = {shift_q[SHORT_REG_WD-2:0], mosi_s};

	// ------------------------------
	// frame state machine
	// ------------------------------
	always_ff @(posedge clk_spi_sample) begin
		if (!rst_n) begin
			state <= st_idle;
			bit_cnt <= '0;
			opcode_q <= '0;
			rd_pulse <= 1'b0;
			wr_pulse <= 1'b0;
		end else begin
			rd_pulse <= 1'b0;
			wr_pulse <= 1'b0;
			if (cs_s) begin
				// deselect drops any unfinished frame
				state <= st_idle;
				bit_cnt <= '0;
			end else begin
				case (state)
					st_idle: begin
						// only a fresh select starts a frame
						if (cs_fall) begin
							state <= st_opcode;
							bit_cnt <= '0;
						end
					end
					st_opcode: begin
						if (sclk_rise) begin
							bit_cnt <= bit_cnt + 4'd1;
							if (bit_cnt == OPC_LAST) begin
								bit_cnt <= '0;
								opcode_q <= field_word[OPCODE_WD-1:0];
								if (field_word[OPCODE_WD-1:0] == OPC_READ ||
										field_word[OPCODE_WD-1:0] == OPC_WRITE) begin
									state <= st_addr;
								end else begin
									// unknown opcode, wait for deselect
									state <= st_idle;
								end
							end
						end
					end
					st_addr: begin
						if (sclk_rise) begin
							// counter wraps to zero after the last bit
							bit_cnt <= bit_cnt + 4'd1;
							if (bit_cnt == WORD_LAST) begin
								if (opcode_q == OPC_READ) begin
									rd_pulse <= 1'b1;
									state <= st_idle;
								end else begin
									state <= st_data;
								end
							end
						end
					end
					st_data: begin
						if (sclk_rise) begin
							bit_cnt <= bit_cnt + 4'd1;
							if (bit_cnt == WORD_LAST) begin
								wr_pulse <= 1'b1;
								state <= st_idle;
							end
						end
					end
					default: state <= st_idle;
				endcase
			end
		end
	end

	// field payload
	always_ff @(posedge clk_spi_sample) begin
		if (sclk_rise) begin
			shift_q <= field_word;
		end
		if (sclk_rise && bit_cnt == WORD_LAST) begin
			if (state == st_addr) begin
				addr_q <= field_word;
			end
			if (state == st_data) begin
				wdata_q <= field_word;
			end
		end
	end

	assign cmd = '{rd_en: rd_pulse, wr_en: wr_pulse, addr: addr_q, wdata: wdata_q};

	// read and write commands are exclusive
	a_cmd_excl: assert property (@(posedge clk_spi_sample) disable iff (!rst_n)
		!(cmd.rd_en && cmd.wr_en));

endmodule

`default_nettype wire

// File: verilog/spi_reg_pkg.sv
`default_nettype none

package spi_reg_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int SPI_ADDR_LENGTH = 16;
	localparam int SHORT_REG_WD = 16;
	localparam int OPCODE_WD = 8;
	// only the low address bits take part in decoding
	localparam int DEC_ADDR_WD = 9;

	typedef logic [SPI_ADDR_LENGTH-1:0] spi_addr_t;
	typedef logic [SHORT_REG_WD-1:0] reg_data_t;
	typedef logic [OPCODE_WD-1:0] opcode_t;
	typedef logic [DEC_ADDR_WD-1:0] reg_idx_t;

	// ------------------------------
	// opcodes and address map
	// ------------------------------
	localparam opcode_t OPC_WRITE = 8'h02;
	localparam opcode_t OPC_READ = 8'h03;

	// four control registers, base kept 4-aligned
	localparam reg_idx_t CTRL_BASE = 9'h010;

	// frame assembly states
	typedef enum logic [1:0] {
		st_idle,
		st_opcode,
		st_addr,
		st_data
	} frame_state_t;

	// register command from the frame decoder
	typedef struct packed {
		logic rd_en;
		logic wr_en;
		spi_addr_t addr;
		reg_data_t wdata;
	} reg_cmd_t;

	// reply of one register list
	typedef struct packed {
		logic sel;
		reg_data_t data;
	} reg_rd_t;

	typedef struct packed {
		reg_data_t ctrl0;
		reg_data_t ctrl1;
		reg_data_t ctrl2;
		reg_data_t ctrl3;
	} ctrl_regs_t;

endpackage

`default_nettype wire
